// ==== logic/apb_defs.svh ====
`ifndef APB_DEFS_SVH
`define APB_DEFS_SVH

// Bus widths
`define APB_ADDR_W 32
`define APB_DATA_W 32

// Storage depths in words
`define REGFILE_WORDS 16
`define SCRATCH_WORDS 256

// Address map by top nibble of paddr
`define REGFILE_BASE_NIBBLE 4'h0
`define SLOW_BASE_NIBBLE    4'hA
`define SLOW_END_NIBBLE     4'hC

// Slow window timing model
`define DELAY_RATIO   3
`define DELAY_SCALE   8
`define DELAY_COUNT_W 10

`endif

// ==== logic/apb_pkg.sv ====
`include "apb_defs.svh"

package apb_pkg;

    typedef struct packed {
        logic [`APB_ADDR_W-1:0]   paddr;
        logic                     psel;
        logic                     penable;
        logic [2:0]               pprot;
        logic                     pwrite;
        logic [`APB_DATA_W-1:0]   pwdata;
        logic [`APB_DATA_W/8-1:0] pstrb;
    } apb_req_t;

    typedef struct packed {
        logic                   pready;
        logic [`APB_DATA_W-1:0] prdata;
        logic                   pslverr;
    } apb_rsp_t;

endpackage

// ==== logic/subsys_pkg.sv ====
package subsys_pkg;

    // Slow window delayer
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        REQ  = 2'b01,
        HOLD = 2'b10
    } delay_state_t;

    // Decoder target
    typedef enum logic [1:0] {
        REG_REGION  = 2'b00,
        SLOW_REGION = 2'b01,
        NO_REGION   = 2'b10
    } region_t;

endpackage

// ==== logic/apb_decoder.sv ====
`timescale 1ns/1ps
`include "apb_defs.svh"

module apb_decoder (
    input  apb_pkg::apb_req_t bus_req,
    output apb_pkg::apb_rsp_t bus_rsp,
    output apb_pkg::apb_req_t reg_req,
    input  apb_pkg::apb_rsp_t reg_rsp,
    output apb_pkg::apb_req_t slow_req,
    input  apb_pkg::apb_rsp_t slow_rsp
);
    import apb_pkg::*;
    import subsys_pkg::*;

    logic [3:0] nibble;
    region_t    region;
    apb_rsp_t   err_rsp;

    assign nibble = bus_req.paddr[`APB_ADDR_W-1 -: 4];

    always_comb begin
        if (nibble == `REGFILE_BASE_NIBBLE) begin
            region = REG_REGION;
        end else if (nibble >= `SLOW_BASE_NIBBLE && nibble < `SLOW_END_NIBBLE) begin
            region = SLOW_REGION;
        end else begin
            region = NO_REGION;
        end
    end

    // Unmapped access completes at once with an error
    always_comb begin
        err_rsp         = '0;
        err_rsp.pready  = bus_req.psel & bus_req.penable;
        err_rsp.pslverr = bus_req.psel & bus_req.penable;
    end

    always_comb begin
        reg_req       = bus_req;
        reg_req.psel  = bus_req.psel && (region == REG_REGION);
        slow_req      = bus_req;
        slow_req.psel = bus_req.psel && (region == SLOW_REGION);
    end

    always_comb begin
        case (region)
            REG_REGION: begin
                bus_rsp = reg_rsp;
            end
            SLOW_REGION: begin
                bus_rsp = slow_rsp;
            end
            default: begin
                bus_rsp = err_rsp;
            end
        endcase
    end

endmodule

// ==== logic/apb_delayer.sv ====
`timescale 1ns/1ps
`include "apb_defs.svh"

module apb_delayer #(
    parameter int RATIO = `DELAY_RATIO,
    parameter int SCALE = `DELAY_SCALE
) (
    input  logic              clock,
    input  logic              reset,
    input  apb_pkg::apb_req_t in_req,
    output apb_pkg::apb_rsp_t in_rsp,
    output apb_pkg::apb_req_t out_req,
    input  apb_pkg::apb_rsp_t out_rsp
);
    import apb_pkg::*;
    import subsys_pkg::*;

    localparam int CW    = `DELAY_COUNT_W;
    localparam int SHIFT = $clog2(SCALE);
    localparam logic [CW-1:0] STEP = CW'(RATIO << SHIFT); // Fixed point, one native cycle

    delay_state_t  state;
    logic [CW-1:0] count;
    logic [CW-1:0] count_sum;
    logic          release_rsp;
    apb_rsp_t      held_rsp;

    // Request goes straight to the slave
    assign out_req = in_req;

    assign count_sum   = count + STEP;
    assign release_rsp = (state == HOLD) && (count == CW'(1));

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (in_req.psel) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    if (out_rsp.pready) begin
                        state <= HOLD;
                    end
                end
                HOLD: begin
                    if (release_rsp) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Answer cycle is counted too, so the scaled count is never zero
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else begin
            case (state)
                REQ: begin
                    if (out_rsp.pready) begin
                        count <= count_sum >> SHIFT;
                    end else begin
                        count <= count_sum;
                    end
                end
                HOLD: begin
                    count <= count - 1'b1;
                end
                default: begin
                    count <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == REQ && out_rsp.pready) begin
            held_rsp <= out_rsp; // Pready is high in the copy
        end
    end

    assign in_rsp = release_rsp ? held_rsp : '0;

endmodule

// ==== logic/apb_regfile.sv ====
`timescale 1ns/1ps
`include "apb_defs.svh"

module apb_regfile (
    input  logic              clock,
    input  logic              reset,
    input  apb_pkg::apb_req_t req,
    output apb_pkg::apb_rsp_t rsp
);
    localparam int WORDS = `REGFILE_WORDS;
    localparam int IDX_W = $clog2(WORDS);
    localparam int LANES = `APB_DATA_W / 8;

    logic [`APB_DATA_W-1:0] regs [WORDS];
    logic [`APB_ADDR_W-7:0] word_addr;
    logic [IDX_W-1:0]       idx;
    logic                   access;
    logic                   in_range;
    logic                   wr_en;

    assign word_addr = req.paddr[`APB_ADDR_W-5:2]; // Top nibble is the region
    assign idx       = word_addr[IDX_W-1:0];
    assign in_range  = word_addr < WORDS;
    assign access    = req.psel & req.penable;
    assign wr_en     = access & req.pwrite & in_range;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < WORDS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            for (int b = 0; b < LANES; b++) begin
                if (req.pstrb[b]) begin
                    regs[idx][b*8 +: 8] <= req.pwdata[b*8 +: 8];
                end
            end
        end
    end

    // Zero wait, done in the first access cycle
    always_comb begin
        rsp.pready  = access;
        rsp.pslverr = access & ~in_range;
        if (access && !req.pwrite && in_range) begin
            rsp.prdata = regs[idx];
        end else begin
            rsp.prdata = '0;
        end
    end

endmodule

// ==== logic/apb_scratch_mem.sv ====
`timescale 1ns/1ps
`include "apb_defs.svh"

module apb_scratch_mem (
    input  logic              clock,
    input  logic              reset,
    input  apb_pkg::apb_req_t req,
    output apb_pkg::apb_rsp_t rsp
);
    localparam int WORDS = `SCRATCH_WORDS;
    localparam int IDX_W = $clog2(WORDS);
    localparam int LANES = `APB_DATA_W / 8;

    logic [`APB_DATA_W-1:0] mem [WORDS];
    logic [`APB_DATA_W-1:0] rdata_q;
    logic [IDX_W-1:0]       idx;
    logic                   access;
    logic                   waited;

    assign idx    = req.paddr[IDX_W+1:2]; // Aliases across the window
    assign access = req.psel & req.penable;

    // One wait state per access
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            waited <= 1'b0;
        end else if (access) begin
            waited <= ~waited;
        end else begin
            waited <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (access && !waited) begin
            rdata_q <= mem[idx]; // Read during the wait cycle
        end
        if (access && waited && req.pwrite) begin
            for (int b = 0; b < LANES; b++) begin
                if (req.pstrb[b]) begin
                    mem[idx][b*8 +: 8] <= req.pwdata[b*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        rsp.pready  = access & waited;
        rsp.pslverr = 1'b0;
        if (access && waited && !req.pwrite) begin
            rsp.prdata = rdata_q;
        end else begin
            rsp.prdata = '0;
        end
    end

endmodule

// ==== logic/apb_subsys_top.sv ====
`timescale 1ns/1ps

module apb_subsys_top (
    input  logic              clock,
    input  logic              reset,
    input  apb_pkg::apb_req_t bus_req,
    output apb_pkg::apb_rsp_t bus_rsp
);
    import apb_pkg::*;

    apb_req_t reg_req;
    apb_rsp_t reg_rsp;
    apb_req_t slow_req;
    apb_rsp_t slow_rsp;
    apb_req_t mem_req;
    apb_rsp_t mem_rsp;

    apb_decoder u_decoder (
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp),
        .reg_req  (reg_req),
        .reg_rsp  (reg_rsp),
        .slow_req (slow_req),
        .slow_rsp (slow_rsp)
    );

    apb_regfile u_regfile (
        .clock (clock),
        .reset (reset),
        .req   (reg_req),
        .rsp   (reg_rsp)
    );

    // Slow window branch
    apb_delayer u_delayer (
        .clock   (clock),
        .reset   (reset),
        .in_req  (slow_req),
        .in_rsp  (slow_rsp),
        .out_req (mem_req),
        .out_rsp (mem_rsp)
    );

    apb_scratch_mem u_scratch_mem (
        .clock (clock),
        .reset (reset),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

endmodule

// ==== verification/apb_subsys_tb.sv ====
`timescale 1ns/1ps
`include "apb_defs.svh"

module apb_subsys_tb;
    import apb_pkg::*;

    typedef struct packed {
        logic [`APB_ADDR_W-1:0] addr;
        logic                   write;
        apb_rsp_t               exp;
        apb_rsp_t               act;
    } xfer_rec_t;

    localparam int RESET_CYCLES    = 16;
    localparam int CYCLES_PER_XFER = 40;
    localparam int N_REG_RW        = 3 * `REGFILE_WORDS; // Read, write, read back
    localparam int N_FILL          = `SCRATCH_WORDS;
    localparam int N_STROBE        = 16;
    localparam int N_SLOW          = 11;
    localparam int N_ERRORS        = 10;
    localparam int N_RANDOM        = 200;
    localparam int N_XFERS = N_REG_RW + N_FILL + N_STROBE + N_SLOW + N_ERRORS + N_RANDOM;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + CYCLES_PER_XFER * N_XFERS;
    localparam logic [15:0] STROBE_SET = 16'b1010_1000_0110_0001;
    localparam int LANES = `APB_DATA_W / 8;
    localparam int REG_CYCLES  = 1; // Pready in the first access cycle
    localparam int MEM_CYCLES  = 2; // One wait state
    localparam int SLOW_CYCLES = MEM_CYCLES * (1 + `DELAY_RATIO); // Slave time plus the hold

    logic     clock;
    logic     reset;
    apb_req_t bus_req;
    apb_rsp_t bus_rsp;

    logic [`APB_DATA_W-1:0] reg_shadow [`REGFILE_WORDS];
    logic [`APB_DATA_W-1:0] scratch_shadow [`SCRATCH_WORDS];

    xfer_rec_t pending [$];
    event      rec_pushed;
    int        issued;
    int        checked;
    int        errors;
    int        test_start_errors;
    int        tests_passed;
    int        tests_failed;
    string     test_name;

    apb_subsys_top dut (
        .clock   (clock),
        .reset   (reset),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp)
    );

    initial clock = 1'b0;
    always #5 clock = ~clock;

    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return addr ^ {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic logic [31:0] apply_strobe(input logic [31:0] old_word,
                                                 input logic [31:0] new_word,
                                                 input logic [3:0]  strb);
        logic [31:0] result;
        result = old_word;
        for (int b = 0; b < LANES; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    // Shadow arrays follow every write
    function automatic apb_rsp_t model_access(input logic [31:0] addr, input logic write,
                                              input logic [31:0] wdata, input logic [3:0] strb);
        apb_rsp_t exp;
        int       word;
        int       idx;
        exp        = '0;
        exp.pready = 1'b1;
        word       = int'(addr[27:2]); // Top nibble selects the region
        case (addr[31:28])
            4'h0: begin
                if (word >= `REGFILE_WORDS) begin
                    exp.pslverr = 1'b1;
                end else if (write) begin
                    reg_shadow[word] = apply_strobe(reg_shadow[word], wdata, strb);
                end else begin
                    exp.prdata = reg_shadow[word];
                end
            end
            4'hA, 4'hB: begin
                idx = word % `SCRATCH_WORDS; // Memory aliases over the window
                if (write) begin
                    scratch_shadow[idx] = apply_strobe(scratch_shadow[idx], wdata, strb);
                end else begin
                    exp.prdata = scratch_shadow[idx];
                end
            end
            default: begin
                exp.pslverr = 1'b1;
            end
        endcase
        return exp;
    endfunction

    task automatic bus_xfer(input logic [31:0] addr, input logic write, input logic [31:0] wdata,
                            input logic [3:0] strb, output int cycles);
        xfer_rec_t rec;
        logic      done;
        rec.addr  = addr;
        rec.write = write;
        rec.exp   = model_access(addr, write, wdata, strb);
        rec.act   = '0;
        @(negedge clock);
        bus_req.paddr   = addr; // Setup phase
        bus_req.psel    = 1'b1;
        bus_req.penable = 1'b0;
        bus_req.pprot   = 3'b000;
        bus_req.pwrite  = write;
        bus_req.pwdata  = wdata;
        bus_req.pstrb   = strb;
        @(negedge clock);
        bus_req.penable = 1'b1;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(posedge clock);
            cycles++;
            if (bus_rsp.pready) begin
                rec.act = bus_rsp;
                done    = 1'b1;
            end
        end
        pending.push_back(rec);
        issued++;
        -> rec_pushed;
        @(negedge clock);
        bus_req.psel    = 1'b0;
        bus_req.penable = 1'b0;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        int cycles;
        bus_xfer(addr, 1'b1, data, strb, cycles);
    endtask

    task automatic read_word(input logic [31:0] addr, output int cycles);
        bus_xfer(addr, 1'b0, '0, 4'h0, cycles);
    endtask

    initial begin : compare_proc
        xfer_rec_t rec;
        forever begin
            @(rec_pushed);
            while (pending.size() != 0) begin
                rec = pending.pop_front();
                assert (rec.act.pslverr === rec.exp.pslverr) else begin
                    $display("[ERROR] %s, pslverr at %h, expected %0b, actual %0b",
                             test_name, rec.addr, rec.exp.pslverr, rec.act.pslverr);
                    errors++;
                end
                if (!rec.write) begin
                    assert (rec.act.prdata === rec.exp.prdata) else begin
                        $display("[ERROR] %s, prdata at %h, expected %h, actual %h",
                                 test_name, rec.addr, rec.exp.prdata, rec.act.prdata);
                        errors++;
                    end
                end
                checked++;
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    task automatic start_test(input string name);
        test_name         = name;
        test_start_errors = errors;
    endtask

    task automatic finish_test();
        wait (checked == issued);
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("test %-12s ok", test_name);
        end else begin
            tests_failed++;
            $display("test %-12s FAILED with %0d error(s)", test_name, errors - test_start_errors);
        end
    endtask

    task automatic regfile_round_trip();
        int cycles;
        start_test("regfile_rw");
        for (int i = 0; i < `REGFILE_WORDS; i++) begin
            read_word(32'(i) << 2, cycles); // Zero after reset
        end
        for (int i = 0; i < `REGFILE_WORDS; i++) begin
            write_word(32'(i) << 2, fill_word(32'(i) << 2), 4'hF);
        end
        for (int i = 0; i < `REGFILE_WORDS; i++) begin
            read_word(32'(i) << 2, cycles);
        end
        finish_test();
    endtask

    task automatic fill_scratch();
        logic [31:0] addr;
        start_test("scratch_fill");
        for (int i = 0; i < `SCRATCH_WORDS; i++) begin
            addr = 32'hA000_0000 | (32'(i) << 2);
            write_word(addr, fill_word(addr), 4'hF);
        end
        finish_test();
    endtask

    task automatic strobe_writes();
        logic [31:0] addr;
        logic [3:0]  strb;
        int          cycles;
        start_test("strobes");
        for (int i = 0; i < 4; i++) begin
            strb = STROBE_SET[i*4 +: 4];
            addr = 32'(2 + i * 4) << 2;
            write_word(addr, $urandom, strb);
            read_word(addr, cycles);
            addr = 32'hB000_0000 | (32'(i * 37 + 3) << 2);
            write_word(addr, $urandom, strb);
            read_word(addr, cycles);
        end
        finish_test();
    endtask

    task automatic slow_window_timing();
        logic [31:0] slow_addrs [4];
        int          reg_cycles;
        int          slow_cycles;
        slow_addrs[0] = 32'hA000_0100;
        slow_addrs[1] = 32'hA7FF_FF04;
        slow_addrs[2] = 32'hB000_0208;
        slow_addrs[3] = 32'hBFFF_FFFC;
        start_test("slow_window");
        read_word(32'h0000_0008, reg_cycles);
        assert (reg_cycles == REG_CYCLES) else begin
            $display("[ERROR] %s, register read cycles, expected %0d, actual %0d",
                     test_name, REG_CYCLES, reg_cycles);
            errors++;
        end
        for (int i = 0; i < 4; i++) begin
            write_word(slow_addrs[i], $urandom, 4'hF);
            read_word(slow_addrs[i], slow_cycles);
            assert (slow_cycles > reg_cycles) else begin
                $display("Slow read at %h took %0d cycles, not more than the register read (%0d)",
                         slow_addrs[i], slow_cycles, reg_cycles);
                errors++;
            end
            assert (slow_cycles == SLOW_CYCLES) else begin
                $display("[ERROR] %s, cycles at %h, expected %0d, actual %0d",
                         test_name, slow_addrs[i], SLOW_CYCLES, slow_cycles);
                errors++;
            end
        end
        write_word(32'hA000_0000, 32'h1357_9bdf, 4'hF);
        read_word(32'hB000_0400, slow_cycles); // Same word through the alias
        finish_test();
    endtask

    task automatic error_responses();
        logic [31:0] bad_addrs [4];
        int          cycles;
        bad_addrs[0] = 32'h0000_0040;
        bad_addrs[1] = 32'h0FFF_FFFC;
        bad_addrs[2] = 32'h5000_0000;
        bad_addrs[3] = 32'hC000_0004;
        start_test("errors");
        for (int i = 0; i < 4; i++) begin
            write_word(bad_addrs[i], 32'hdead_beef, 4'hF);
            read_word(bad_addrs[i], cycles);
        end
        read_word(32'h0000_0000, cycles); // Stored data must be intact
        read_word(32'hA000_0000, cycles);
        finish_test();
    endtask

    task automatic random_mix();
        logic [31:0] addr;
        int          pick;
        int          nib;
        int          cycles;
        start_test("random_mix");
        repeat (N_RANDOM) begin
            pick = int'($urandom_range(0, 9));
            if (pick < 4) begin
                addr = 32'($urandom_range(0, `REGFILE_WORDS - 1)) << 2;
            end else if (pick == 4) begin
                addr = 32'($urandom_range(`REGFILE_WORDS, 4095)) << 2;
            end else if (pick < 8) begin
                addr        = $urandom;
                addr[31:28] = 4'hA + 4'($urandom_range(0, 1));
                addr[1:0]   = 2'b00;
            end else begin
                nib = int'($urandom_range(1, 13));
                if (nib > 9) begin
                    nib += 2; // Skip the slow window
                end
                addr        = $urandom;
                addr[31:28] = 4'(nib);
                addr[1:0]   = 2'b00;
            end
            bus_xfer(addr, 1'($urandom_range(0, 1)), $urandom, 4'($urandom_range(0, 15)), cycles);
        end
        finish_test();
    endtask

    initial begin : main
        void'($urandom(32'hb167_3f75));
        bus_req = '0;
        reset   = 1'b1;
        for (int i = 0; i < `REGFILE_WORDS; i++) begin
            reg_shadow[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clock);
        reset = 1'b0;
        regfile_round_trip();
        fill_scratch();
        strobe_writes();
        slow_window_timing();
        error_responses();
        random_mix();
        $display("Tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, checked, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+logic
logic/apb_pkg.sv
logic/subsys_pkg.sv
logic/apb_decoder.sv
logic/apb_delayer.sv
logic/apb_regfile.sv
logic/apb_scratch_mem.sv
logic/apb_subsys_top.sv
verification/apb_subsys_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := apb_subsys_tb
FILELIST  := compile.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)
LOG       := sim.log
PASS_MSG  := Simulation passed

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell grep -v '^+' $(FILELIST)) logic/apb_defs.svh
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	@$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
